//--- design/draw_geom_pkg.sv
package draw_geom_pkg;

	// lane count is set by the display layout
	localparam int NUM_LANES = 4;

	localparam int LANE_TOP = 200;    // first line of lane 0
	localparam int LANE_HEIGHT = 60;  // lines per lane and sprite column stride
	localparam int TRACK_WIDTH = 420; // key indicator starts here

	// one past the last line of lane 3
	localparam int TRACK_BOTTOM = LANE_TOP + NUM_LANES * LANE_HEIGHT;

	typedef logic [9:0] coord_t; // screen x or y

	typedef logic [$clog2(NUM_LANES)-1:0] lane_t;

	typedef logic [NUM_LANES-1:0] lane_mask_t; // bit i is lane i

endpackage

//--- design/draw_sprite_pkg.sv
package draw_sprite_pkg;

	typedef logic [14:0] sprite_addr_t;
	typedef logic [15:0] sprite_word_t;
	typedef logic [7:0] x_idx_t; // horizontal sprite index of a note
	typedef logic [3:0] color_t;

	typedef enum logic [2:0] {
		NOTE_NONE        = 3'd0,
		NOTE_CLICK       = 3'd1,
		NOTE_SLIDE_BEGIN = 3'd2,
		NOTE_SLIDE_END   = 3'd3,
		NOTE_SLIDE_SPACE = 3'd4
	} note_kind_e;

	// as presented by a note engine
	typedef struct packed {
		note_kind_e kind;
		logic discarded; // slide already missed
		x_idx_t x_idx;
	} note_info_t;

	// field order matches rom word bits 11:0
	typedef struct packed {
		color_t blue;
		color_t green;
		color_t red;
	} rgb_t;

	// sprite sheet layout
	localparam sprite_addr_t BASE_CLICK            = 15'd12480;
	localparam sprite_addr_t BASE_SLIDE_BEGIN      = 15'd14640;
	localparam sprite_addr_t BASE_SLIDE_BEGIN_DISC = 15'd15720;
	localparam sprite_addr_t BASE_SLIDE_END        = 15'd16800;
	localparam sprite_addr_t BASE_SLIDE_END_DISC   = 15'd17880;
	localparam sprite_addr_t BASE_SLIDE_SPACE      = 15'd18960;
	localparam sprite_addr_t BASE_SLIDE_SPACE_DISC = 15'd19020;
	localparam sprite_addr_t BASE_KEY_DOWN         = 15'd19080;
	localparam sprite_addr_t BASE_KEY_UP           = 15'd22680;

	// edges from the enabling edge to the color latch
	localparam int FETCH_LATENCY = 3;

endpackage

//--- design/frame_ctrl.sv
module frame_ctrl
	import draw_geom_pkg::*;
(
	input  logic             CLK,
	input  logic             RESET_L,
	input  logic             sig_on,
	input  lane_mask_t [1:0] refresh_done,
	output logic             sig_done,
	output lane_mask_t       refresh_lane,
	output logic             refresh_bank,
	output logic             display_bank,
	output logic             first_frame,
	output logic             fetch_enable,
	output logic             vga_reset
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REFRESH,
		ST_WAIT,
		ST_DONE
	} state_e;

	state_e state;
	state_e state_nxt;
	lane_t lane;
	logic working;
	logic fill_bank;

	// frame flags and ping-pong bank
	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			working <= 1'b0;
			first_frame <= 1'b1;
			fill_bank <= 1'b0;
		end else if (sig_on) begin
			fill_bank <= ~fill_bank;
			if (!working)
				working <= 1'b1;
			else
				first_frame <= 1'b0;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE:
				if (sig_on)
					state_nxt = ST_REFRESH;
			ST_REFRESH:
				state_nxt = ST_WAIT;
			ST_WAIT:
				if (refresh_done[fill_bank][lane])
					state_nxt = (lane == lane_t'(NUM_LANES - 1)) ? ST_DONE : ST_REFRESH;
			ST_DONE:
				state_nxt = ST_IDLE;
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			state <= ST_IDLE;
			lane <= '0;
		end else begin
			state <= state_nxt;
			if (state == ST_IDLE)
				lane <= '0;
			else if (state == ST_WAIT && state_nxt == ST_REFRESH)
				lane <= lane + 1'b1; // on to the next lane
		end
	end

	assign refresh_lane = (state == ST_REFRESH) ? lane_mask_t'(1) << lane : '0;
	assign sig_done = (state == ST_DONE);

	assign refresh_bank = fill_bank;
	assign display_bank = ~fill_bank; // show the bank filled last frame
	assign fetch_enable = ~first_frame;
	assign vga_reset = ~working;

	// a later lane goes out only after the lane before it reported done
	a_refresh_order: assert property (@(posedge CLK) disable iff (!RESET_L)
		refresh_lane != '0 && !refresh_lane[0] |->
			$past(state == ST_WAIT && refresh_done[fill_bank][lane]));

endmodule

//--- design/sprite_addr_gen.sv
module sprite_addr_gen
	import draw_geom_pkg::*;
	import draw_sprite_pkg::*;
(
	input  logic                              CLK,
	input  logic                              RESET_L,
	input  logic                              vga_request,
	input  logic                              fetch_enable,
	input  coord_t                            vga_x,
	input  coord_t                            vga_y,
	input  logic                              display_bank,
	input  note_info_t [1:0][NUM_LANES-1:0]   note_info,
	input  lane_mask_t                        key_down,
	output sprite_addr_t                      rom_addr
);

	coord_t rel_y;
	coord_t line;
	lane_t lane;
	logic in_track;
	logic in_key;
	note_info_t sel_note;
	sprite_addr_t note_base;
	sprite_addr_t key_base;
	sprite_addr_t addr_nxt;

	// lane decode
	assign in_track = (vga_y >= coord_t'(LANE_TOP)) && (vga_y < coord_t'(TRACK_BOTTOM));
	assign rel_y = vga_y - coord_t'(LANE_TOP);
	assign lane = lane_t'(rel_y / LANE_HEIGHT);
	assign line = coord_t'(rel_y % LANE_HEIGHT); // line within the lane
	assign in_key = (vga_x >= coord_t'(TRACK_WIDTH));

	assign sel_note = note_info[display_bank][lane];

	always_comb begin
		case (sel_note.kind)
			NOTE_CLICK:
				note_base = BASE_CLICK;
			NOTE_SLIDE_BEGIN:
				note_base = sel_note.discarded ? BASE_SLIDE_BEGIN_DISC : BASE_SLIDE_BEGIN;
			NOTE_SLIDE_END:
				note_base = sel_note.discarded ? BASE_SLIDE_END_DISC : BASE_SLIDE_END;
			NOTE_SLIDE_SPACE:
				note_base = sel_note.discarded ? BASE_SLIDE_SPACE_DISC : BASE_SLIDE_SPACE;
			default:
				note_base = '0;
		endcase
	end

	assign key_base = key_down[lane] ? BASE_KEY_DOWN : BASE_KEY_UP;

	// sums wrap at the rom width
	always_comb begin
		if (!in_track)
			addr_nxt = '0;
		else if (in_key)
			addr_nxt = sprite_addr_t'(key_base
				+ (vga_x - coord_t'(TRACK_WIDTH)) * LANE_HEIGHT + line);
		else if (sel_note.kind == NOTE_NONE)
			addr_nxt = '0; // empty lane
		else
			addr_nxt = sprite_addr_t'(note_base + sel_note.x_idx * LANE_HEIGHT + line);
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L)
			rom_addr <= '0;
		else if (vga_request && fetch_enable)
			rom_addr <= addr_nxt;
	end

	// note engines must present a defined kind wherever a note is drawn
	a_note_kind: assert property (@(posedge CLK) disable iff (!RESET_L)
		vga_request && fetch_enable && in_track && !in_key |->
			sel_note.kind inside {NOTE_NONE, NOTE_CLICK, NOTE_SLIDE_BEGIN,
				NOTE_SLIDE_END, NOTE_SLIDE_SPACE});

endmodule

//--- design/pixel_fetch.sv
module pixel_fetch
	import draw_sprite_pkg::*;
(
	input  logic         CLK,
	input  logic         RESET_L,
	input  logic         vga_request,
	input  logic         fetch_enable,
	input  logic         first_frame,
	input  sprite_word_t rom_data,
	output logic         rom_en,
	output rgb_t         vga_rgb
);

	typedef logic [$clog2(FETCH_LATENCY + 1)-1:0] lat_cnt_t;

	logic busy;
	lat_cnt_t lat_cnt;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			busy <= 1'b0;
			lat_cnt <= '0;
			rom_en <= 1'b0;
			vga_rgb <= '0;
		end else begin
			if (busy) begin
				lat_cnt <= lat_cnt + 1'b1;
				if (lat_cnt == lat_cnt_t'(FETCH_LATENCY)) begin
					vga_rgb <= rgb_t'(rom_data[$bits(rgb_t)-1:0]);
					rom_en <= 1'b0;
					busy <= 1'b0;
				end
			end
			if (vga_request) begin
				if (first_frame) begin
					vga_rgb <= '0; // blank until the first bank is filled
				end else if (fetch_enable) begin
					rom_en <= 1'b1;
					busy <= 1'b1;
					lat_cnt <= lat_cnt_t'(1);
				end
			end
		end
	end

	// pixel rate leaves room for a full read between requests
	a_no_overlap: assert property (@(posedge CLK) disable iff (!RESET_L)
		busy |-> !vga_request);

endmodule

//--- design/note_draw_top.sv
module note_draw_top
	import draw_geom_pkg::*;
	import draw_sprite_pkg::*;
(
	input  logic                            CLK,
	input  logic                            RESET_L,
	input  logic                            sig_on,
	output logic                            sig_done,
	output lane_mask_t                      refresh_lane,
	output logic                            refresh_bank,
	input  lane_mask_t [1:0]                refresh_done,
	input  note_info_t [1:0][NUM_LANES-1:0] note_info,
	input  lane_mask_t                      key_down,
	input  coord_t                          vga_x,
	input  coord_t                          vga_y,
	input  logic                            vga_request,
	output logic                            vga_reset,
	output rgb_t                            vga_rgb,
	output sprite_addr_t                    rom_addr,
	output logic                            rom_en,
	input  sprite_word_t                    rom_data
);

	logic display_bank;
	logic first_frame;
	logic fetch_enable;

	frame_ctrl u_frame_ctrl (
		.CLK          (CLK),
		.RESET_L      (RESET_L),
		.sig_on       (sig_on),
		.refresh_done (refresh_done),
		.sig_done     (sig_done),
		.refresh_lane (refresh_lane),
		.refresh_bank (refresh_bank),
		.display_bank (display_bank),
		.first_frame  (first_frame),
		.fetch_enable (fetch_enable),
		.vga_reset    (vga_reset)
	);

	sprite_addr_gen u_sprite_addr_gen (
		.CLK          (CLK),
		.RESET_L      (RESET_L),
		.vga_request  (vga_request),
		.fetch_enable (fetch_enable),
		.vga_x        (vga_x),
		.vga_y        (vga_y),
		.display_bank (display_bank),
		.note_info    (note_info),
		.key_down     (key_down),
		.rom_addr     (rom_addr)
	);

	// rom read timing and color latch
	pixel_fetch u_pixel_fetch (
		.CLK          (CLK),
		.RESET_L      (RESET_L),
		.vga_request  (vga_request),
		.fetch_enable (fetch_enable),
		.first_frame  (first_frame),
		.rom_data     (rom_data),
		.rom_en       (rom_en),
		.vga_rgb      (vga_rgb)
	);

endmodule

//--- testbench/note_draw_tb.sv
module note_draw_tb
	import draw_geom_pkg::*;
	import draw_sprite_pkg::*;
();

	localparam int WAIT_LIMIT = 200;

	typedef struct packed {
		logic fetch;
		sprite_addr_t addr;
	} pending_t;

	logic CLK;
	logic RESET_L;
	logic sig_on;
	logic sig_done;
	lane_mask_t refresh_lane;
	logic refresh_bank;
	lane_mask_t [1:0] refresh_done = '0;
	note_info_t [1:0][NUM_LANES-1:0] note_info;
	lane_mask_t key_down;
	coord_t vga_x;
	coord_t vga_y;
	logic vga_request;
	logic vga_reset;
	rgb_t vga_rgb;
	sprite_addr_t rom_addr;
	logic rom_en;
	sprite_word_t rom_data = '0;

	int seed = 32'h69a7cd60;
	int errors = 0;
	int requests = 0;
	int frames = 0;
	int done_count = 0;
	logic fill_model = 1'b0; // bank the engines are filling
	pending_t pending_q[$];

	note_draw_top note_draw_top_inst (.*);

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic sprite_word_t rom_word(input sprite_addr_t addr);
		return {1'b0, addr} ^ 16'h5a3c;
	endfunction

	function automatic sprite_addr_t expected_addr(input coord_t x, input coord_t y,
			input logic bank, input note_info_t [1:0][NUM_LANES-1:0] notes,
			input lane_mask_t keys);
		int lane;
		int line;
		int base;
		note_info_t n;
		if (y < LANE_TOP || y >= LANE_TOP + NUM_LANES * LANE_HEIGHT)
			return '0;
		lane = (y - LANE_TOP) / LANE_HEIGHT;
		line = (y - LANE_TOP) % LANE_HEIGHT;
		if (x >= TRACK_WIDTH) begin
			base = keys[lane] ? BASE_KEY_DOWN : BASE_KEY_UP;
			return sprite_addr_t'(base + (x - TRACK_WIDTH) * LANE_HEIGHT + line);
		end
		n = notes[bank][lane];
		case (n.kind)
			NOTE_CLICK: base = BASE_CLICK;
			NOTE_SLIDE_BEGIN: base = n.discarded ? BASE_SLIDE_BEGIN_DISC : BASE_SLIDE_BEGIN;
			NOTE_SLIDE_END: base = n.discarded ? BASE_SLIDE_END_DISC : BASE_SLIDE_END;
			NOTE_SLIDE_SPACE: base = n.discarded ? BASE_SLIDE_SPACE_DISC : BASE_SLIDE_SPACE;
			default: return '0;
		endcase
		return sprite_addr_t'(base + n.x_idx * LANE_HEIGHT + line);
	endfunction

	function automatic note_info_t random_note();
		note_info_t n;
		n.kind = note_kind_e'(rand_range(0, 4));
		n.discarded = 1'(rand_range(0, 1));
		n.x_idx = x_idx_t'(rand_range(0, 255));
		return n;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp) else begin
			errors++;
			$display("FAIL %s: expected %h, got %h", name, exp, got);
		end
	endtask

	task automatic next_cycle();
		@(posedge CLK);
		#5;
	endtask

	task automatic randomize_bank(input logic bank);
		for (int l = 0; l < NUM_LANES; l++)
			note_info[bank][l] = random_note();
	endtask

	task automatic pixel_request(input coord_t x, input coord_t y);
		pending_t entry;
		entry.fetch = (frames >= 2);
		entry.addr = expected_addr(x, y, ~fill_model, note_info, key_down);
		pending_q.push_back(entry);
		vga_x = x;
		vga_y = y;
		vga_request = 1'b1;
		next_cycle();
		vga_request = 1'b0;
		repeat (FETCH_LATENCY) next_cycle(); // pixel rate spacing
		requests++;
	endtask

	function automatic coord_t lane_row(input int lane);
		return coord_t'(LANE_TOP + lane * LANE_HEIGHT + rand_range(0, LANE_HEIGHT - 1));
	endfunction

	task automatic run_frame();
		int cycles;
		int done_before;
		fill_model = ~fill_model;
		frames++;
		done_before = done_count;
		sig_on = 1'b1;
		next_cycle();
		sig_on = 1'b0;
		for (int lane = 0; lane < NUM_LANES; lane++) begin
			cycles = 0;
			while (refresh_lane == '0 && cycles < WAIT_LIMIT) begin
				next_cycle();
				cycles++;
			end
			assert (refresh_lane != '0) else begin
				errors++;
				$display("timeout waiting for the refresh request of lane %0d", lane);
			end
			assert (refresh_lane == lane_mask_t'(1 << lane)) else begin
				errors++;
				$display("FAIL refresh_lane: expected %h, got %h", 1 << lane, refresh_lane);
			end
			assert (refresh_bank == fill_model) else begin
				errors++;
				$display("FAIL refresh_bank: expected %h, got %h", fill_model, refresh_bank);
			end
			if (lane > 0) begin
				assert (refresh_done[fill_model][lane - 1]) else begin
					errors++;
					$display("lane %0d was requested before lane %0d reported done",
						lane, lane - 1);
				end
			end
			assert (done_count == done_before) else begin
				errors++;
				$display("frame done pulsed before lane %0d was refreshed", lane);
			end
			next_cycle();
		end
		cycles = 0;
		while (done_count == done_before && cycles < WAIT_LIMIT) begin
			next_cycle();
			cycles++;
		end
		assert (refresh_done[fill_model][NUM_LANES - 1]) else begin
			errors++;
			$display("frame done pulsed before lane %0d reported done", NUM_LANES - 1);
		end
		repeat (3) next_cycle();
		assert (done_count == done_before + 1) else begin
			errors++;
			$display("expected one frame done pulse, saw %0d", done_count - done_before);
		end
	endtask

	// note engine model serving one request at a time
	always @(posedge CLK) begin : note_engine
		lane_t req_lane;
		logic req_bank;
		int delay;
		#1;
		if (refresh_lane != '0) begin
			req_bank = refresh_bank;
			for (int i = 0; i < NUM_LANES; i++)
				if (refresh_lane[i])
					req_lane = lane_t'(i);
			#4;
			refresh_done[req_bank][req_lane] = 1'b0;
			delay = rand_range(1, 6);
			repeat (delay) @(posedge CLK);
			#5;
			refresh_done[req_bank][req_lane] = 1'b1;
		end
	end

	always @(posedge CLK) begin
		if (rom_en)
			rom_data <= rom_word(rom_addr);
	end

	always @(posedge CLK) begin
		#1;
		if (sig_done)
			done_count++;
	end

	always @(posedge CLK) begin : compare
		pending_t entry;
		sprite_word_t word;
		rgb_t exp_rgb;
		if (pending_q.size() > 0) begin
			entry = pending_q.pop_front(); // request sampled at this edge
			#1;
			if (entry.fetch) begin
				assert (rom_addr == entry.addr) else begin
					errors++;
					$display("FAIL rom_addr: expected %h, got %h", entry.addr, rom_addr);
				end
				assert (rom_en) else begin
					errors++;
					$display("FAIL rom_en: expected 1, got %h", rom_en);
				end
				repeat (FETCH_LATENCY) @(posedge CLK);
				#1;
				word = rom_word(entry.addr);
				exp_rgb.red = word[3:0];
				exp_rgb.green = word[7:4];
				exp_rgb.blue = word[11:8];
				assert (vga_rgb == exp_rgb) else begin
					errors++;
					$display("FAIL vga_rgb: expected %h, got %h", exp_rgb, vga_rgb);
				end
				assert (!rom_en) else begin
					errors++;
					$display("FAIL rom_en: expected 0, got %h", rom_en);
				end
			end else begin
				assert (!rom_en && vga_rgb == '0) else begin
					errors++;
					$display("FAIL rom_en/vga_rgb: expected 0/000, got %h/%h", rom_en, vga_rgb);
				end
			end
		end
	end

	initial begin : stimulus
		int l;
		RESET_L = 1'b0;
		sig_on = 1'b0;
		note_info = '0;
		key_down = '0;
		vga_x = '0;
		vga_y = '0;
		vga_request = 1'b0;
		repeat (4) @(posedge CLK);
		#5;
		check_value("vga_reset", vga_reset, 1);
		check_value("sig_done", sig_done, 0);
		check_value("rom_en", rom_en, 0);
		check_value("refresh_lane", refresh_lane, 0);
		check_value("vga_rgb", vga_rgb, 0);
		check_value("rom_addr", rom_addr, 0);
		RESET_L = 1'b1;
		randomize_bank(1'b0);
		randomize_bank(1'b1);
		run_frame();
		assert (!vga_reset) else begin
			errors++;
			$display("FAIL vga_reset: expected 0, got %h", vga_reset);
		end
		repeat (4) pixel_request(coord_t'(rand_range(0, 639)), lane_row(rand_range(0, 3)));
		randomize_bank(fill_model);
		run_frame();
		for (int i = 0; i < 30; i++) begin
			if (i % 8 == 0)
				randomize_bank(~fill_model);
			pixel_request(coord_t'(rand_range(0, TRACK_WIDTH - 1)), lane_row(rand_range(0, 3)));
		end
		// every kind both plain and discarded
		for (int k = 0; k < 10; k++) begin
			l = k % NUM_LANES;
			note_info[~fill_model][l] = '{note_kind_e'(k / 2), 1'(k % 2),
				x_idx_t'(rand_range(0, 255))};
			pixel_request(coord_t'(rand_range(0, TRACK_WIDTH - 1)), lane_row(l));
		end
		for (int i = 0; i < 12; i++) begin
			key_down = lane_mask_t'(rand_range(0, 15));
			pixel_request(coord_t'(rand_range(TRACK_WIDTH, 639)), lane_row(rand_range(0, 3)));
		end
		for (int i = 0; i < 8; i++)
			pixel_request(coord_t'(rand_range(0, 639)),
				coord_t'(rand_range(0, 1) ? rand_range(0, 199) : rand_range(440, 524)));
		// fill bank edits stay hidden until the swap
		l = rand_range(0, 3);
		note_info[~fill_model][l] = '{NOTE_CLICK, 1'b0, 8'd5};
		note_info[fill_model][l] = '{NOTE_SLIDE_END, 1'b0, 8'd9};
		vga_y = lane_row(l);
		pixel_request(coord_t'(100), vga_y);
		run_frame();
		pixel_request(coord_t'(100), vga_y);
		run_frame();
		for (int i = 0; i < 8; i++)
			pixel_request(coord_t'(rand_range(0, 639)), lane_row(rand_range(0, 3)));
		repeat (2) next_cycle();
		$display("%0d frames, %0d pixel requests, %0d errors", frames, requests, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- note_draw.f
design/draw_geom_pkg.sv
design/draw_sprite_pkg.sv
design/frame_ctrl.sv
design/sprite_addr_gen.sv
design/pixel_fetch.sv
design/note_draw_top.sv
testbench/note_draw_tb.sv
